//--- Bender.yml
package:
  name: acq_readout

sources:
  - rtl/acq_readout_pkg.sv
  - rtl/circ_buf_ram.sv
  - rtl/trig_addr_fifo.sv
  - rtl/cbuf_readout_seq.sv
  - rtl/acq_word_builder.sv
  - rtl/acq_readout_top.sv
  - target: test
    files:
      - bench/acq_readout_assertions.sv
      - bench/acq_readout_tb.sv

//--- bench/acq_readout_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module acq_readout_assertions (
  input logic                                   adc_clk,
  input logic                                   reset_clk_adc,
  input logic [acq_readout_pkg::NUM_STATES-1:0] cur_state,
  input logic                                   trig_addr_rd_en,
  input logic                                   trig_fifo_empty,
  input logic                                   select_fill_hdr,
  input logic                                   select_dat,
  input logic                                   select_waveform_hdr,
  input logic                                   select_checksum
);

  int unsigned fails = 0;  // read by the testbench at the end of the run

  state_one_hot: assert property (@(posedge adc_clk) disable iff (reset_clk_adc)
    $onehot(cur_state))
    else begin
      fails++;
      $error("sequencer state is not one-hot");
    end

  // the pop must always find an entry in the trigger fifo
  pop_not_empty: assert property (@(posedge adc_clk) disable iff (reset_clk_adc)
    trig_addr_rd_en |-> !trig_fifo_empty)
    else begin
      fails++;
      $error("trigger fifo popped while empty");
    end

  select_exclusive: assert property (@(posedge adc_clk) disable iff (reset_clk_adc)
    $onehot0({select_fill_hdr, select_dat, select_waveform_hdr, select_checksum}))
    else begin
      fails++;
      $error("more than one output select active");
    end

endmodule

bind cbuf_readout_seq acq_readout_assertions u_seq_assertions (
  .adc_clk(adc_clk),
  .reset_clk_adc(reset_clk_adc),
  .cur_state(cur_state),
  .trig_addr_rd_en(trig_addr_rd_en),
  .trig_fifo_empty(trig_fifo_empty),
  .select_fill_hdr(select_fill_hdr),
  .select_dat(select_dat),
  .select_waveform_hdr(select_waveform_hdr),
  .select_checksum(select_checksum)
);

`default_nettype wire

//--- bench/acq_readout_tb.sv
`timescale 1ns/100ps
`default_nettype none

module acq_readout_tb;
  import acq_readout_pkg::*;

  logic                     adc_clk = 1'b0;
  logic                     reset_clk_adc;
  logic [SAMPLE_WORD_W-1:0] adc_word;
  logic                     adc_word_valid;
  logic                     trig;
  logic                     cbuf_rd_en;
  logic                     cbuf_trig_en;
  acq_word_t                acq_out_word;
  logic                     acq_out_valid;
  logic [BURST_ADR_W-1:0]   acq_out_burst_adr;
  logic                     cbuf_rd_trig_wait;
  logic                     trig_dropped;

  logic [31:0]              lfsr_state = 32'h72f3_1442;
  logic [SAMPLE_WORD_W-1:0] model_mem [CBUF_WORDS];  // mirror of the circular buffer
  logic [CBUF_ADDR_W-1:0]   model_wr_ptr;
  logic [CBUF_ADDR_W-1:0]   wr_ptr_now;  // dut write pointer during this cycle
  acq_word_t                exp_word_q[$];
  logic [BURST_ADR_W-1:0]   exp_adr_q[$];
  bit                       exp_last_q[$];  // last burst of a waveform
  logic [FILL_NUM_W-1:0]    fill_num;
  logic [WFM_NUM_W-1:0]     wfm_count;
  logic [BURST_ADR_W-1:0]   next_adr;
  logic [SAMPLE_WORD_W-1:0] exp_checksum;
  int                       words_in_fill;
  int                       pending_wfms;
  int                       errors;
  int                       test_errors;
  int                       tests_run;
  bit                       adc_run;
  bit                       timed_out;
  string                    test_name;

  always #20 adc_clk = ~adc_clk;

  acq_readout_top dut (.*);

  // taps 32,22,2,1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_word(input string what, input acq_word_t exp, input acq_word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_adr(input string what, input logic [BURST_ADR_W-1:0] exp,
                           input logic [BURST_ADR_W-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic report_timeout(input string msg);
    $display("TIMEOUT in %s: %s", test_name, msg);
    timed_out = 1'b1;
    test_errors++;
  endtask

  task automatic add_to_checksum(input acq_word_t w);
    for (int l = 0; l < WORDS_PER_BURST; l++)
      exp_checksum += w.lanes[l];  // 32-bit wrap
  endtask

  task automatic expect_word(input acq_word_t w, input logic [BURST_ADR_W-1:0] adr,
                             input bit summed, input bit last);
    exp_word_q.push_back(w);
    exp_adr_q.push_back(adr);
    exp_last_q.push_back(last);
    if (summed)
      add_to_checksum(w);
  endtask

  // one clock: check outputs at the falling edge, then drive new inputs
  task automatic tick();
    logic [31:0] s0;
    logic [31:0] s1;
    @(negedge adc_clk);
    check_flag("trig_dropped", 1'b0, trig_dropped);  // never more than two queued
    if (acq_out_valid === 1'b1) begin
      if (exp_word_q.size() == 0) begin
        $display("ERROR in %s: unexpected output word at burst %0d", test_name,
                 acq_out_burst_adr);
        test_errors++;
      end else begin
        check_word("output word", exp_word_q.pop_front(), acq_out_word);
        check_adr("burst address", exp_adr_q.pop_front(), acq_out_burst_adr);
        if (exp_last_q.pop_front())
          pending_wfms--;
      end
    end
    trig = 1'b0;
    wr_ptr_now = model_wr_ptr;
    adc_word_valid = adc_run && (rand_bits(2) != 0);  // about three cycles in four
    s0 = rand_bits(12);
    s1 = rand_bits(12);
    adc_word = {4'h0, s1[11:0], 4'h0, s0[11:0]};  // two 12-bit samples
    if (adc_word_valid) begin
      model_mem[model_wr_ptr] = adc_word;
      model_wr_ptr++;
      words_in_fill++;
    end
  endtask

  task automatic wait_trig_wait();
    for (int n = 0; n < 20 && cbuf_rd_trig_wait !== 1'b1; n++)
      tick();
    if (cbuf_rd_trig_wait !== 1'b1)
      report_timeout("cbuf_rd_trig_wait never rose");
  endtask

  task automatic wait_fill_words();
    for (int n = 0; n < 200 && words_in_fill < PRETRIG_WORDS; n++)
      tick();
    if (words_in_fill < PRETRIG_WORDS)
      report_timeout("too few sample words written for a pre-trigger window");
  endtask

  task automatic wait_pending_below(input int limit);
    for (int n = 0; n < 400 && pending_wfms >= limit; n++)
      tick();
    if (pending_wfms >= limit)
      report_timeout("queued waveforms were not read out");
  endtask

  task automatic wait_drained();
    for (int n = 0; n < 400 && exp_word_q.size() != 0; n++)
      tick();
    if (exp_word_q.size() != 0)
      report_timeout("expected output words never appeared");
  endtask

  task automatic start_fill();
    words_in_fill = 0;
    wfm_count = '0;
    next_adr = BURST_ADR_W'(1);
    exp_checksum = '0;
    cbuf_rd_en = 1'b1;
    cbuf_trig_en = 1'b1;
  endtask

  // strobe trig this cycle and queue the header and bursts it must produce
  task automatic issue_trigger();
    acq_word_t              w;
    logic [CBUF_ADDR_W-1:0] start;
    start = wr_ptr_now - CBUF_ADDR_W'(PRETRIG_WORDS);
    trig = 1'b1;
    wfm_count++;
    pending_wfms++;
    w = '0;
    w.hdr.tag = HDR_TAG_WAVEFORM;
    w.hdr.fill_num = fill_num;
    w.hdr.wfm_num = wfm_count;
    w.hdr.trig_addr = 16'(start);
    w.hdr.burst_adr = next_adr;
    expect_word(w, next_adr, 1'b1, 1'b0);
    next_adr++;
    for (int b = 0; b < BURSTS_PER_WAVEFORM; b++) begin
      for (int l = 0; l < WORDS_PER_BURST; l++)
        w.lanes[l] = model_mem[start + CBUF_ADDR_W'(b * WORDS_PER_BURST + l)];
      expect_word(w, next_adr, 1'b1, b == BURSTS_PER_WAVEFORM - 1);
      next_adr++;
    end
  endtask

  task automatic end_fill();
    acq_word_t w;
    acq_word_t c;
    cbuf_rd_en = 1'b0;
    cbuf_trig_en = 1'b0;
    w = '0;
    w.hdr.tag = HDR_TAG_FILL;
    w.hdr.fill_num = fill_num;
    w.hdr.wfm_num = wfm_count;
    w.hdr.burst_adr = next_adr;  // checksum address
    add_to_checksum(w);
    c = '0;
    c.lanes[0] = exp_checksum;
    expect_word(c, next_adr, 1'b0, 1'b0);
    expect_word(w, '0, 1'b0, 1'b0);  // fill header always at burst 0
    fill_num++;
  endtask

  task automatic finish_test();
    $display("%-18s %s (%0d errors)", test_name, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
    errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  initial begin
    reset_clk_adc = 1'b1;
    adc_word = '0;
    adc_word_valid = 1'b0;
    trig = 1'b0;
    cbuf_rd_en = 1'b0;
    cbuf_trig_en = 1'b0;
    model_wr_ptr = '0;
    fill_num = '0;
    {words_in_fill, pending_wfms, errors, test_errors, tests_run} = '0;
    {adc_run, timed_out} = '0;
    test_name = "reset_and_enable";
    repeat (16) tick();
    reset_clk_adc = 1'b0;
    adc_run = 1'b1;
    tick();
    check_flag("acq_out_valid", 1'b0, acq_out_valid);
    check_flag("cbuf_rd_trig_wait", 1'b0, cbuf_rd_trig_wait);
    start_fill();
    wait_trig_wait();
    finish_test();
    if (!timed_out) begin
      test_name = "single_trigger";
      wait_fill_words();
      tick();
      issue_trigger();
      wait_drained();
      finish_test();
    end
    if (!timed_out) begin
      test_name = "random_triggers";
      for (int i = 0; i < 6; i++) begin
        wait_pending_below((i == 3) ? 1 : 2);  // pair goes into an empty fifo
        repeat (rand_bits(5) + 1) tick();
        issue_trigger();
        if (i == 3) begin
          tick();
          issue_trigger();  // back-to-back
        end
      end
      wait_drained();
      finish_test();
    end
    if (!timed_out) begin
      test_name = "fill_end";
      tick();
      end_fill();
      wait_drained();
      finish_test();
    end
    if (!timed_out) begin
      test_name = "empty_fill";
      tick();
      start_fill();
      wait_trig_wait();
      tick();
      end_fill();
      wait_drained();
      repeat (12) tick();  // nothing else may come out
      finish_test();
    end
    errors += dut.u_cbuf_readout_seq.u_seq_assertions.fails;
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0 && !timed_out)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/acq_readout_pkg.sv
`default_nettype none

package acq_readout_pkg;

  localparam int CBUF_ADDR_W = 10;  // 1024-word circular buffer
  localparam int CBUF_WORDS = 1 << CBUF_ADDR_W;
  localparam int SAMPLE_WORD_W = 32;  // two 12-bit adc samples per word
  localparam int PRETRIG_WORDS = 32;  // one whole waveform behind the write pointer
  localparam int BURSTS_PER_WAVEFORM = 8;
  localparam int WORDS_PER_BURST = 4;  // 4 x 32 = one 128-bit ddr3 burst
  localparam int BURST_CNTR_W = $clog2(BURSTS_PER_WAVEFORM + 1);
  localparam int TRIG_FIFO_DEPTH = 4;
  localparam int TRIG_PTR_W = $clog2(TRIG_FIFO_DEPTH);
  localparam int BURST_ADR_W = 24;
  localparam int WFM_NUM_W = 16;
  localparam int FILL_NUM_W = 16;

  localparam logic [7:0] HDR_TAG_WAVEFORM = 8'hA5;
  localparam logic [7:0] HDR_TAG_FILL = 8'h5A;

  // bit positions of the one-hot readout sequencer state
  localparam int ST_IDLE = 0;
  localparam int ST_FILL_INIT1 = 1;
  localparam int ST_TRIG_WAIT = 2;
  localparam int ST_WAVEFORM_INIT1 = 3;
  localparam int ST_WAVEFORM_INIT2 = 4;
  localparam int ST_WAVEFORM_INIT3 = 5;
  localparam int ST_LOOP1 = 6;  // LOOP1..LOOP4 must stay contiguous
  localparam int ST_LOOP2 = 7;
  localparam int ST_LOOP3 = 8;
  localparam int ST_LOOP4 = 9;
  localparam int ST_WAVEFORM_DONE1 = 10;
  localparam int ST_WAVEFORM_DONE2 = 11;
  localparam int ST_NO_TRIGGER = 12;
  localparam int ST_FILL_DONE1 = 13;
  localparam int ST_FILL_DONE2 = 14;
  localparam int ST_FILL_DONE3 = 15;
  localparam int ST_FILL_DONE4 = 16;
  localparam int ST_DONE = 17;
  localparam int NUM_STATES = 18;

  // one 128-bit output word, read either as data lanes or as header fields
  typedef union packed {
    logic [WORDS_PER_BURST-1:0][SAMPLE_WORD_W-1:0] lanes;  // lane 0 = oldest buffer word
    struct packed {
      logic [7:0]             tag;
      logic [FILL_NUM_W-1:0]  fill_num;
      logic [WFM_NUM_W-1:0]   wfm_num;  // waveform number, or count in a fill header
      logic [15:0]            trig_addr;  // buffer start address, zero-extended
      logic [BURST_ADR_W-1:0] burst_adr;
      logic [47:0]            spare;
    } hdr;
  } acq_word_t;

endpackage

`default_nettype wire

//--- rtl/acq_readout_top.sv
`timescale 1ns/100ps
`default_nettype none

module acq_readout_top (
  input  logic                                     adc_clk,
  input  logic                                     reset_clk_adc,
  input  logic [acq_readout_pkg::SAMPLE_WORD_W-1:0] adc_word,
  input  logic                                     adc_word_valid,
  input  logic                                     trig,
  input  logic                                     cbuf_rd_en,
  input  logic                                     cbuf_trig_en,
  output acq_readout_pkg::acq_word_t               acq_out_word,
  output logic                                     acq_out_valid,
  output logic [acq_readout_pkg::BURST_ADR_W-1:0]   acq_out_burst_adr,
  output logic                                     cbuf_rd_trig_wait,
  output logic                                     trig_dropped
);
  import acq_readout_pkg::*;

  logic [CBUF_ADDR_W-1:0]   rd_addr;
  logic [SAMPLE_WORD_W-1:0] rd_data;
  logic [CBUF_ADDR_W-1:0]   trig_start_addr;  // buffer -> trigger fifo
  logic [CBUF_ADDR_W-1:0]   trig_addr;  // fifo head -> builder
  logic                     trig_fifo_empty;
  logic                     trig_addr_rd_en;
  logic                     burst_cntr_zero;
  // sequencer strobes into the word builder
  logic                     burst_adr_cntr_init;
  logic                     init_circ_buf_rd_addr;
  logic                     inc_circ_buf_rd_addr;
  logic                     latch_circ_buf_dat;
  logic                     select_fill_hdr;
  logic                     select_dat;
  logic                     select_waveform_hdr;
  logic                     select_checksum;
  logic                     checksum_update;
  logic                     checksum_init;
  logic                     adc_acq_out_valid;
  logic                     burst_adr_cntr_en;
  logic                     save_start_adr;
  logic                     save_last_adr;
  logic                     burst_cntr_init;
  logic                     burst_cntr_en;
  logic                     waveform_cntr_init;
  logic                     waveform_cntr_en;
  logic                     fill_cntr_en;

  circ_buf_ram u_circ_buf_ram (.*);

  trig_addr_fifo u_trig_addr_fifo (.*);

  cbuf_readout_seq u_cbuf_readout_seq (.*);

  acq_word_builder u_acq_word_builder (.*);

endmodule

`default_nettype wire

//--- rtl/acq_word_builder.sv
`timescale 1ns/100ps
`default_nettype none

module acq_word_builder (
  input  logic                                     adc_clk,
  input  logic                                     reset_clk_adc,
  input  logic                                     init_circ_buf_rd_addr,
  input  logic                                     inc_circ_buf_rd_addr,
  input  logic                                     latch_circ_buf_dat,
  input  logic                                     select_waveform_hdr,
  input  logic                                     select_dat,
  input  logic                                     select_checksum,
  input  logic                                     select_fill_hdr,
  input  logic                                     checksum_init,
  input  logic                                     checksum_update,
  input  logic                                     burst_adr_cntr_init,
  input  logic                                     burst_adr_cntr_en,
  input  logic                                     save_start_adr,
  input  logic                                     save_last_adr,
  input  logic                                     burst_cntr_init,
  input  logic                                     burst_cntr_en,
  input  logic                                     waveform_cntr_init,
  input  logic                                     waveform_cntr_en,
  input  logic                                     fill_cntr_en,
  input  logic                                     adc_acq_out_valid,
  input  logic [acq_readout_pkg::CBUF_ADDR_W-1:0]   trig_addr,
  input  logic [acq_readout_pkg::SAMPLE_WORD_W-1:0] rd_data,
  output logic [acq_readout_pkg::CBUF_ADDR_W-1:0]   rd_addr,
  output logic                                     burst_cntr_zero,
  output acq_readout_pkg::acq_word_t               acq_out_word,
  output logic                                     acq_out_valid,
  output logic [acq_readout_pkg::BURST_ADR_W-1:0]   acq_out_burst_adr
);
  import acq_readout_pkg::*;

  logic [WORDS_PER_BURST-1:0][SAMPLE_WORD_W-1:0] burst_lanes;  // shift latch
  logic [BURST_CNTR_W-1:0]  burst_cntr;  // bursts left in the waveform
  logic [WFM_NUM_W-1:0]     waveform_cntr;
  logic [FILL_NUM_W-1:0]    fill_cntr;
  logic [BURST_ADR_W-1:0]   burst_adr;  // next free ddr3 burst
  logic [BURST_ADR_W-1:0]   start_adr;  // header address of the current waveform
  logic [BURST_ADR_W-1:0]   last_adr;  // where the checksum will land
  logic [CBUF_ADDR_W-1:0]   trig_addr_q;
  logic [SAMPLE_WORD_W-1:0] checksum;
  acq_word_t                waveform_hdr;
  acq_word_t                fill_hdr;
  acq_word_t                checksum_word;

  function automatic logic [SAMPLE_WORD_W-1:0] lane_sum(input acq_word_t w);
    logic [SAMPLE_WORD_W-1:0] sum;
    sum = '0;
    for (int i = 0; i < WORDS_PER_BURST; i++)
      sum += w.lanes[i];  // wraps at 32 bits
    return sum;
  endfunction

  always_comb begin
    waveform_hdr = '0;
    waveform_hdr.hdr.tag = HDR_TAG_WAVEFORM;
    waveform_hdr.hdr.fill_num = fill_cntr;
    waveform_hdr.hdr.wfm_num = waveform_cntr;
    waveform_hdr.hdr.trig_addr = 16'(trig_addr_q);
    waveform_hdr.hdr.burst_adr = start_adr;
    fill_hdr = '0;
    fill_hdr.hdr.tag = HDR_TAG_FILL;
    fill_hdr.hdr.fill_num = fill_cntr;
    fill_hdr.hdr.wfm_num = waveform_cntr;  // number of waveforms in the fill
    fill_hdr.hdr.burst_adr = last_adr;
    checksum_word = '0;
    checksum_word.lanes[0] = checksum;
  end

  always_ff @(posedge adc_clk) begin
    if (reset_clk_adc) begin
      burst_cntr <= '0;
      waveform_cntr <= '0;
      fill_cntr <= '0;
      burst_adr <= '0;
      checksum <= '0;
    end else begin
      if (burst_cntr_init)
        burst_cntr <= BURST_CNTR_W'(BURSTS_PER_WAVEFORM);
      else if (burst_cntr_en)
        burst_cntr <= burst_cntr - 1'b1;
      if (waveform_cntr_init)
        waveform_cntr <= '0;
      else if (waveform_cntr_en)
        waveform_cntr <= waveform_cntr + 1'b1;  // first waveform is number 1
      if (fill_cntr_en)
        fill_cntr <= fill_cntr + 1'b1;
      if (burst_adr_cntr_init)
        burst_adr <= BURST_ADR_W'(1);  // burst 0 is kept for the fill header
      else if (burst_adr_cntr_en)
        burst_adr <= burst_adr + 1'b1;
      if (checksum_init)
        checksum <= '0;
      else if (checksum_update)  // fill header is summed straight off the mux input
        checksum <= checksum + lane_sum(select_fill_hdr ? fill_hdr : acq_out_word);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (init_circ_buf_rd_addr) begin
      rd_addr <= trig_addr;
      trig_addr_q <= trig_addr;
    end else if (inc_circ_buf_rd_addr) begin
      rd_addr <= rd_addr + 1'b1;
    end
    if (save_start_adr)
      start_adr <= burst_adr;
    if (save_last_adr)
      last_adr <= burst_adr;
    if (latch_circ_buf_dat)
      burst_lanes <= {rd_data, burst_lanes[WORDS_PER_BURST-1:1]};  // newest enters lane 3
    // output mux, holds between selects
    if (select_waveform_hdr)
      acq_out_word <= waveform_hdr;
    else if (select_dat)
      acq_out_word.lanes <= burst_lanes;
    else if (select_checksum)
      acq_out_word <= checksum_word;
    else if (select_fill_hdr)
      acq_out_word <= fill_hdr;
    if (select_fill_hdr)
      acq_out_burst_adr <= '0;  // fill header always at burst 0
    else if (burst_adr_cntr_en)
      acq_out_burst_adr <= burst_adr;  // address the word being written takes
  end

  assign burst_cntr_zero = (burst_cntr == '0);
  assign acq_out_valid = adc_acq_out_valid;

endmodule

`default_nettype wire

//--- rtl/cbuf_readout_seq.sv
`timescale 1ns/100ps
`default_nettype none

module cbuf_readout_seq (
  input  logic adc_clk,
  input  logic reset_clk_adc,
  input  logic cbuf_rd_en,  // rising edge starts a fill
  input  logic cbuf_trig_en,  // falling edge ends the fill
  input  logic trig_fifo_empty,
  input  logic burst_cntr_zero,  // last burst of the waveform is being read
  output logic cbuf_rd_trig_wait,
  output logic burst_adr_cntr_init,
  output logic init_circ_buf_rd_addr,
  output logic inc_circ_buf_rd_addr,
  output logic latch_circ_buf_dat,
  output logic select_fill_hdr,
  output logic select_dat,
  output logic select_waveform_hdr,
  output logic select_checksum,
  output logic checksum_update,
  output logic checksum_init,
  output logic adc_acq_out_valid,
  output logic burst_adr_cntr_en,
  output logic save_start_adr,
  output logic save_last_adr,
  output logic trig_addr_rd_en,
  output logic burst_cntr_init,
  output logic burst_cntr_en,
  output logic waveform_cntr_init,
  output logic waveform_cntr_en,
  output logic fill_cntr_en
);
  import acq_readout_pkg::*;

  logic [NUM_STATES-1:0] cur_state;
  logic [NUM_STATES-1:0] nxt_state;
  logic                  got_trig;  // at least one waveform in this fill
  logic                  loop_next;
  logic                  immed_adc_acq_out_valid;  // header and checksum writes
  logic                  start_dlyd_adc_acq_out_valid;  // stage 1, burst read finishing
  logic                  dlyd_adc_acq_out_valid;  // stage 2, burst latched in the builder

  always_ff @(posedge adc_clk) begin
    if (reset_clk_adc)
      cur_state <= NUM_STATES'(1) << ST_IDLE;
    else
      cur_state <= nxt_state;
  end

  always_comb begin
    nxt_state = '0;
    case (1'b1)
      cur_state[ST_IDLE]:           nxt_state[cbuf_rd_en ? ST_FILL_INIT1 : ST_IDLE] = 1'b1;
      cur_state[ST_FILL_INIT1]:     nxt_state[ST_TRIG_WAIT] = 1'b1;
      cur_state[ST_TRIG_WAIT]: begin
        if (!trig_fifo_empty)
          nxt_state[ST_WAVEFORM_INIT1] = 1'b1;  // queued triggers drain before the fill ends
        else if (!cbuf_trig_en)
          nxt_state[got_trig ? ST_FILL_DONE1 : ST_NO_TRIGGER] = 1'b1;
        else
          nxt_state[ST_TRIG_WAIT] = 1'b1;
      end
      cur_state[ST_WAVEFORM_INIT1]: nxt_state[ST_WAVEFORM_INIT2] = 1'b1;
      cur_state[ST_WAVEFORM_INIT2]: nxt_state[ST_WAVEFORM_INIT3] = 1'b1;
      cur_state[ST_WAVEFORM_INIT3]: nxt_state[ST_LOOP1] = 1'b1;
      cur_state[ST_LOOP1]:          nxt_state[ST_LOOP2] = 1'b1;
      cur_state[ST_LOOP2]:          nxt_state[ST_LOOP3] = 1'b1;
      cur_state[ST_LOOP3]:          nxt_state[ST_LOOP4] = 1'b1;
      cur_state[ST_LOOP4]:          nxt_state[burst_cntr_zero ? ST_WAVEFORM_DONE1 : ST_LOOP1] = 1'b1;
      cur_state[ST_WAVEFORM_DONE1]: nxt_state[ST_WAVEFORM_DONE2] = 1'b1;
      cur_state[ST_WAVEFORM_DONE2]: nxt_state[ST_TRIG_WAIT] = 1'b1;
      cur_state[ST_NO_TRIGGER]:     nxt_state[ST_FILL_DONE1] = 1'b1;
      cur_state[ST_FILL_DONE1]:     nxt_state[ST_FILL_DONE2] = 1'b1;
      cur_state[ST_FILL_DONE2]:     nxt_state[ST_FILL_DONE3] = 1'b1;
      cur_state[ST_FILL_DONE3]:     nxt_state[ST_FILL_DONE4] = 1'b1;
      cur_state[ST_FILL_DONE4]:     nxt_state[ST_DONE] = 1'b1;
      cur_state[ST_DONE]:           nxt_state[ST_IDLE] = 1'b1;
      default:                      nxt_state[ST_IDLE] = 1'b1;  // lost one-hot, restart
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (reset_clk_adc)
      got_trig <= 1'b0;
    else if (nxt_state[ST_FILL_INIT1])
      got_trig <= 1'b0;  // new fill
    else if (nxt_state[ST_WAVEFORM_INIT1])
      got_trig <= 1'b1;
  end

  assign loop_next = |nxt_state[ST_LOOP4:ST_LOOP1];

  // strobes come from the next state, so each is high during its own state
  always_ff @(posedge adc_clk) begin
    if (reset_clk_adc) begin
      {cbuf_rd_trig_wait, burst_adr_cntr_init, checksum_init, waveform_cntr_init,
       init_circ_buf_rd_addr, save_start_adr, trig_addr_rd_en, burst_cntr_init,
       waveform_cntr_en, select_waveform_hdr, immed_adc_acq_out_valid, burst_adr_cntr_en,
       inc_circ_buf_rd_addr, latch_circ_buf_dat, select_dat, burst_cntr_en,
       start_dlyd_adc_acq_out_valid, save_last_adr, select_fill_hdr, select_checksum,
       fill_cntr_en} <= '0;
    end else begin
      cbuf_rd_trig_wait <= nxt_state[ST_TRIG_WAIT];
      burst_adr_cntr_init <= nxt_state[ST_FILL_INIT1];  // first waveform at burst 1
      checksum_init <= nxt_state[ST_FILL_INIT1];
      waveform_cntr_init <= nxt_state[ST_FILL_INIT1];
      init_circ_buf_rd_addr <= nxt_state[ST_WAVEFORM_INIT1];  // load the fifo head
      save_start_adr <= nxt_state[ST_WAVEFORM_INIT1];
      trig_addr_rd_en <= nxt_state[ST_WAVEFORM_INIT1];  // pop after the head is taken
      burst_cntr_init <= nxt_state[ST_WAVEFORM_INIT1];
      waveform_cntr_en <= nxt_state[ST_WAVEFORM_INIT1];
      select_waveform_hdr <= nxt_state[ST_WAVEFORM_INIT2];
      immed_adc_acq_out_valid <= nxt_state[ST_WAVEFORM_INIT3] | nxt_state[ST_FILL_DONE2] |
                                 nxt_state[ST_FILL_DONE3];
      burst_adr_cntr_en <= nxt_state[ST_WAVEFORM_INIT3] | nxt_state[ST_LOOP4] |
                           nxt_state[ST_FILL_DONE2];  // header, burst, checksum
      inc_circ_buf_rd_addr <= nxt_state[ST_WAVEFORM_INIT3] | loop_next;
      // the two done states flush the read pipeline into the burst latch
      latch_circ_buf_dat <= loop_next | nxt_state[ST_WAVEFORM_DONE1] |
                            nxt_state[ST_WAVEFORM_DONE2];
      select_dat <= loop_next | nxt_state[ST_WAVEFORM_DONE1] | nxt_state[ST_WAVEFORM_DONE2];
      burst_cntr_en <= nxt_state[ST_LOOP1];  // once per burst
      start_dlyd_adc_acq_out_valid <= nxt_state[ST_LOOP4];
      save_last_adr <= nxt_state[ST_WAVEFORM_DONE1] | nxt_state[ST_NO_TRIGGER];
      select_fill_hdr <= nxt_state[ST_FILL_DONE1] | nxt_state[ST_FILL_DONE3];
      select_checksum <= nxt_state[ST_FILL_DONE2];
      fill_cntr_en <= nxt_state[ST_DONE];
    end
  end

  // valid delay pipeline, covers the buffer read latency of a burst
  always_ff @(posedge adc_clk) begin
    if (reset_clk_adc) begin
      dlyd_adc_acq_out_valid <= 1'b0;
      adc_acq_out_valid <= 1'b0;
      checksum_update <= 1'b0;
    end else begin
      dlyd_adc_acq_out_valid <= start_dlyd_adc_acq_out_valid;
      adc_acq_out_valid <= immed_adc_acq_out_valid | dlyd_adc_acq_out_valid;
      // data bursts, waveform headers (immed without a fill select), and the fill
      // header once in FILL_DONE1
      checksum_update <= dlyd_adc_acq_out_valid |
                         (immed_adc_acq_out_valid & ~select_checksum & ~select_fill_hdr) |
                         nxt_state[ST_FILL_DONE1];
    end
  end

endmodule

`default_nettype wire

//--- rtl/circ_buf_ram.sv
`timescale 1ns/100ps
`default_nettype none

module circ_buf_ram (
  input  logic                                     adc_clk,
  input  logic                                     reset_clk_adc,
  input  logic [acq_readout_pkg::SAMPLE_WORD_W-1:0] adc_word,  // two packed samples
  input  logic                                     adc_word_valid,
  input  logic [acq_readout_pkg::CBUF_ADDR_W-1:0]   rd_addr,
  output logic [acq_readout_pkg::SAMPLE_WORD_W-1:0] rd_data,  // one cycle after rd_addr
  output logic [acq_readout_pkg::CBUF_ADDR_W-1:0]   trig_start_addr
);
  import acq_readout_pkg::*;

  logic [SAMPLE_WORD_W-1:0] cbuf_mem [CBUF_WORDS];
  logic [CBUF_ADDR_W-1:0]   wr_ptr;  // next location to be written

  always_ff @(posedge adc_clk) begin
    if (reset_clk_adc)
      wr_ptr <= '0;
    else if (adc_word_valid)
      wr_ptr <= wr_ptr + 1'b1;  // wraps at the buffer end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_word_valid)
      cbuf_mem[wr_ptr] <= adc_word;
    rd_data <= cbuf_mem[rd_addr];
  end

  // pre-trigger window start, modulo the buffer size
  assign trig_start_addr = wr_ptr - CBUF_ADDR_W'(PRETRIG_WORDS);

endmodule

`default_nettype wire

//--- rtl/trig_addr_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module trig_addr_fifo (
  input  logic                                   adc_clk,
  input  logic                                   reset_clk_adc,
  input  logic                                   trig,  // one-cycle trigger strobe
  input  logic                                   cbuf_trig_en,
  input  logic [acq_readout_pkg::CBUF_ADDR_W-1:0] trig_start_addr,
  input  logic                                   trig_addr_rd_en,  // pop the head
  output logic [acq_readout_pkg::CBUF_ADDR_W-1:0] trig_addr,  // head, fall-through
  output logic                                   trig_fifo_empty,
  output logic                                   trig_dropped
);
  import acq_readout_pkg::*;

  logic [CBUF_ADDR_W-1:0] fifo_mem [TRIG_FIFO_DEPTH];
  logic [TRIG_PTR_W-1:0]  wr_ptr;
  logic [TRIG_PTR_W-1:0]  rd_ptr;
  logic [TRIG_PTR_W:0]    count;  // occupancy, 0..depth
  logic                   push;
  logic                   full;
  logic                   accept;
  logic                   pop;

  assign push = trig & cbuf_trig_en;  // triggers outside the enable window are ignored
  assign full = (count == (TRIG_PTR_W + 1)'(TRIG_FIFO_DEPTH));
  assign accept = push & ~full;
  assign pop = trig_addr_rd_en & ~trig_fifo_empty;

  always_ff @(posedge adc_clk) begin
    if (reset_clk_adc) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      trig_dropped <= 1'b0;
    end else begin
      trig_dropped <= push & full;  // overflow flag, one cycle
      if (accept)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (accept && !pop)
        count <= count + 1'b1;
      else if (pop && !accept)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (accept)
      fifo_mem[wr_ptr] <= trig_start_addr;
  end

  assign trig_addr = fifo_mem[rd_ptr];
  assign trig_fifo_empty = (count == '0);

endmodule

`default_nettype wire

//--- verilog.f
rtl/acq_readout_pkg.sv
rtl/circ_buf_ram.sv
rtl/trig_addr_fifo.sv
rtl/cbuf_readout_seq.sv
rtl/acq_word_builder.sv
rtl/acq_readout_top.sv
bench/acq_readout_assertions.sv
bench/acq_readout_tb.sv
